//--- cop_defs.svh
`ifndef COP_DEFS_SVH
`define COP_DEFS_SVH

// Data, PC and immediate width
`define COP_XLEN 32

// Packed opcode is {funct7, funct3, major}
`define COP_OPC_W 17
`define COP_MAJ_W 7
`define COP_F3_W 3
`define COP_F7_W 7

// Field offsets inside the packed opcode
`define COP_F3_LSB 7
`define COP_F7_LSB 10

// Register index width
`define COP_REG_W 5

// Exception code width and values
`define COP_EXC_W 4
`define COP_EXC_ILLEGAL 2

// Shift amount width for RV32
`define COP_SHAMT_W 5

`endif

//--- cop_pkg.sv
`default_nettype none

`include "cop_defs.svh"

package cop_pkg;

    // Decoded operations, register forms first
    typedef enum logic [4:0] {
        OP_NONE,
        OP_ADD,
        OP_SUB,
        OP_SLL,
        OP_SLT,
        OP_SLTU,
        OP_XOR,
        OP_SRL,
        OP_SRA,
        OP_OR,
        OP_AND,
        OP_ADDI,
        OP_SLTI,
        OP_SLTIU,
        OP_XORI,
        OP_ORI,
        OP_ANDI,
        OP_SLLI,
        OP_SRLI,
        OP_SRAI,
        OP_ILLEGAL
    } cop_op_e;

    // Major opcodes handled by the coprocessor
    typedef enum logic [`COP_MAJ_W-1:0] {
        MAJ_OP_IMM = 7'b0010011,
        MAJ_OP     = 7'b0110011
    } cop_major_e;

    typedef enum logic [`COP_EXC_W-1:0] {
        EXC_NONE    = '0,
        EXC_ILLEGAL = `COP_EXC_ILLEGAL
    } cop_exc_e;

    typedef struct packed {
        logic [`COP_XLEN-1:0]  pc;
        logic [`COP_OPC_W-1:0] opcode;
        logic [`COP_REG_W-1:0] rd;
        logic [`COP_REG_W-1:0] rs1;
        logic [`COP_REG_W-1:0] rs2;
        logic [`COP_XLEN-1:0]  imm;
    } cop_issue_t;

    typedef struct packed {
        logic                  valid;
        logic                  reg_w_en;
        logic [`COP_REG_W-1:0] reg_w_rd;
        logic [`COP_XLEN-1:0]  reg_w_data;
        logic                  exc_en;
        cop_exc_e              exc_code;
    } cop_result_t;

endpackage

`default_nettype wire

//--- cop_decoder.sv
`default_nettype none

`include "cop_defs.svh"

module cop_decoder (
    input  wire logic [`COP_OPC_W-1:0] opcode,
    output logic                       accept,
    output cop_pkg::cop_op_e           op
);

    logic [`COP_MAJ_W-1:0] major;
    logic [`COP_F3_W-1:0]  funct3;
    logic [`COP_F7_W-1:0]  funct7;

    assign major  = opcode[`COP_MAJ_W-1:0];
    assign funct3 = opcode[`COP_F3_LSB +: `COP_F3_W];
    assign funct7 = opcode[`COP_F7_LSB +: `COP_F7_W];

    always_comb begin
        op = cop_pkg::OP_NONE;
        case (major)
            cop_pkg::MAJ_OP: begin
                if (funct7 == 7'b0000000) begin
                    case (funct3)
                        3'b000: op = cop_pkg::OP_ADD;
                        3'b001: op = cop_pkg::OP_SLL;
                        3'b010: op = cop_pkg::OP_SLT;
                        3'b011: op = cop_pkg::OP_SLTU;
                        3'b100: op = cop_pkg::OP_XOR;
                        3'b101: op = cop_pkg::OP_SRL;
                        3'b110: op = cop_pkg::OP_OR;
                        default: op = cop_pkg::OP_AND;
                    endcase
                end else if (funct7 == 7'b0100000) begin
                    // Only SUB and SRA use the alternate funct7
                    case (funct3)
                        3'b000: op = cop_pkg::OP_SUB;
                        3'b101: op = cop_pkg::OP_SRA;
                        default: op = cop_pkg::OP_NONE;
                    endcase
                end
            end
            cop_pkg::MAJ_OP_IMM: begin
                case (funct3)
                    3'b000: op = cop_pkg::OP_ADDI;
                    3'b010: op = cop_pkg::OP_SLTI;
                    3'b011: op = cop_pkg::OP_SLTIU;
                    3'b100: op = cop_pkg::OP_XORI;
                    3'b110: op = cop_pkg::OP_ORI;
                    3'b111: op = cop_pkg::OP_ANDI;
                    // Reserved shift encodings are accepted but trap
                    3'b001: begin
                        op = (funct7 == 7'b0000000) ? cop_pkg::OP_SLLI
                                                    : cop_pkg::OP_ILLEGAL;
                    end
                    default: begin
                        if (funct7 == 7'b0000000) begin
                            op = cop_pkg::OP_SRLI;
                        end else if (funct7 == 7'b0100000) begin
                            op = cop_pkg::OP_SRAI;
                        end else begin
                            op = cop_pkg::OP_ILLEGAL;
                        end
                    end
                endcase
            end
            default: op = cop_pkg::OP_NONE;
        endcase
    end

    assign accept = (op != cop_pkg::OP_NONE);

endmodule

`default_nettype wire

//--- cop_alu.sv
`default_nettype none

`include "cop_defs.svh"

module cop_alu (
    input  wire cop_pkg::cop_op_e     op,
    input  wire logic [`COP_XLEN-1:0] rs1_data,
    input  wire logic [`COP_XLEN-1:0] rs2_data,
    input  wire logic [`COP_XLEN-1:0] imm,
    output logic [`COP_XLEN-1:0]      result
);

    logic                    use_imm;
    logic [`COP_XLEN-1:0]    operand_b;
    logic [`COP_SHAMT_W-1:0] shamt;
    logic                    lt_signed;
    logic                    lt_unsigned;

    always_comb begin
        case (op)
            cop_pkg::OP_ADDI,
            cop_pkg::OP_SLTI,
            cop_pkg::OP_SLTIU,
            cop_pkg::OP_XORI,
            cop_pkg::OP_ORI,
            cop_pkg::OP_ANDI,
            cop_pkg::OP_SLLI,
            cop_pkg::OP_SRLI,
            cop_pkg::OP_SRAI: use_imm = 1'b1;
            default:          use_imm = 1'b0;
        endcase
    end

    assign operand_b = use_imm ? imm : rs2_data;

    // Upper bits of the amount are ignored on RV32
    assign shamt = operand_b[`COP_SHAMT_W-1:0];

    assign lt_signed   = $signed(rs1_data) < $signed(operand_b);
    assign lt_unsigned = rs1_data < operand_b;

    always_comb begin
        case (op)
            cop_pkg::OP_ADD,
            cop_pkg::OP_ADDI:  result = rs1_data + operand_b;
            cop_pkg::OP_SUB:   result = rs1_data - operand_b;
            cop_pkg::OP_SLL,
            cop_pkg::OP_SLLI:  result = rs1_data << shamt;
            cop_pkg::OP_SLT,
            cop_pkg::OP_SLTI:  result = {{(`COP_XLEN-1){1'b0}}, lt_signed};
            cop_pkg::OP_SLTU,
            cop_pkg::OP_SLTIU: result = {{(`COP_XLEN-1){1'b0}}, lt_unsigned};
            cop_pkg::OP_XOR,
            cop_pkg::OP_XORI:  result = rs1_data ^ operand_b;
            cop_pkg::OP_SRL,
            cop_pkg::OP_SRLI:  result = rs1_data >> shamt;
            cop_pkg::OP_SRA,
            cop_pkg::OP_SRAI:  result = $unsigned($signed(rs1_data) >>> shamt);
            cop_pkg::OP_OR,
            cop_pkg::OP_ORI:   result = rs1_data | operand_b;
            cop_pkg::OP_AND,
            cop_pkg::OP_ANDI:  result = rs1_data & operand_b;
            // None and illegal produce no value
            default:           result = '0;
        endcase
    end

endmodule

`default_nettype wire

//--- cop_mini.sv
`default_nettype none

`include "cop_defs.svh"

module cop_mini (
    input  wire logic                  CLK,
    input  wire logic                  rst,
    input  wire logic                  flush,
    input  wire logic                  advance,

    // Check and ready opcodes
    input  wire logic [`COP_OPC_W-1:0] c_opcode,
    input  wire logic [`COP_OPC_W-1:0] r_opcode,

    // Exec stage
    input  wire cop_pkg::cop_issue_t   e_issue,
    input  wire logic                  e_allow,
    input  wire logic [`COP_XLEN-1:0]  e_rs1_data,
    input  wire logic [`COP_XLEN-1:0]  e_rs2_data,

    output logic                       c_accept,
    output cop_pkg::cop_result_t       e_result
);

    cop_pkg::cop_op_e     r_op;
    cop_pkg::cop_op_e     e_op_q;
    logic [`COP_XLEN-1:0] alu_value;
    logic                 e_live;
    logic                 e_illegal;

    // Only accept matters in check
    cop_decoder u_check_dec (
        .opcode (c_opcode),
        .accept (c_accept),
        .op     ()
    );

    cop_decoder u_ready_dec (
        .opcode (r_opcode),
        .accept (),
        .op     (r_op)
    );

    // Ready decode follows its instruction into exec
    always_ff @(posedge CLK) begin
        if (rst || flush) begin
            e_op_q <= cop_pkg::OP_NONE;
        end else if (advance) begin
            e_op_q <= r_op;
        end
    end

    cop_alu u_alu (
        .op       (e_op_q),
        .rs1_data (e_rs1_data),
        .rs2_data (e_rs2_data),
        .imm      (e_issue.imm),
        .result   (alu_value)
    );

    assign e_live    = (e_op_q != cop_pkg::OP_NONE) && e_allow;
    assign e_illegal = (e_op_q == cop_pkg::OP_ILLEGAL);

    always_comb begin
        e_result.valid      = e_live;
        // x0 is never written
        e_result.reg_w_en   = e_live && !e_illegal && (e_issue.rd != '0);
        e_result.reg_w_rd   = e_issue.rd;
        e_result.reg_w_data = alu_value;
        e_result.exc_en     = e_live && e_illegal;
        e_result.exc_code   = (e_live && e_illegal) ? cop_pkg::EXC_ILLEGAL
                                                    : cop_pkg::EXC_NONE;
    end

endmodule

`default_nettype wire

//--- cop_top.sv
`default_nettype none

`include "cop_defs.svh"

module cop_top (
    // Control
    input  wire logic                 CLK,
    input  wire logic                 rst,
    input  wire logic                 flush,
    input  wire logic                 stall,
    input  wire logic                 mem_wait,

    // Check stage
    input  wire cop_pkg::cop_issue_t  issue,
    output logic                      c_accept,
    output cop_pkg::cop_issue_t       c_issue,

    // Exec stage
    input  wire logic                 allow,
    input  wire logic [`COP_XLEN-1:0] rs1_data,
    input  wire logic [`COP_XLEN-1:0] rs2_data,
    output logic [`COP_XLEN-1:0]      e_pc,
    output cop_pkg::cop_result_t      e_result
);

    logic advance;

    // Stage 0 is check, 1 is ready, 2 is exec
    cop_pkg::cop_issue_t c_stage_q;
    cop_pkg::cop_issue_t r_stage_q;
    cop_pkg::cop_issue_t e_stage_q;

    // Exec side inputs captured with stage 2
    logic                 e_allow_q;
    logic [`COP_XLEN-1:0] e_rs1_data_q;
    logic [`COP_XLEN-1:0] e_rs2_data_q;

    assign advance = !(stall || mem_wait);

    // Flush wins over stall
    always_ff @(posedge CLK) begin
        if (rst || flush) begin
            c_stage_q <= '0;
            r_stage_q <= '0;
            e_stage_q <= '0;
        end else if (advance) begin
            c_stage_q <= issue;
            r_stage_q <= c_stage_q;
            e_stage_q <= r_stage_q;
        end
    end

    always_ff @(posedge CLK) begin
        if (rst || flush) begin
            e_allow_q    <= 1'b0;
            e_rs1_data_q <= '0;
            e_rs2_data_q <= '0;
        end else if (advance) begin
            e_allow_q    <= allow;
            e_rs1_data_q <= rs1_data;
            e_rs2_data_q <= rs2_data;
        end
    end

    assign c_issue = c_stage_q;
    assign e_pc    = e_stage_q.pc;

    cop_mini u_cop_mini (
        .CLK        (CLK),
        .rst        (rst),
        .flush      (flush),
        .advance    (advance),
        .c_opcode   (c_stage_q.opcode),
        .r_opcode   (r_stage_q.opcode),
        .e_issue    (e_stage_q),
        .e_allow    (e_allow_q),
        .e_rs1_data (e_rs1_data_q),
        .e_rs2_data (e_rs2_data_q),
        .c_accept   (c_accept),
        .e_result   (e_result)
    );

endmodule

`default_nettype wire

//--- cop_asserts.sv
`default_nettype none

`include "cop_defs.svh"

module cop_asserts (
    input wire logic                 CLK,
    input wire logic                 rst,
    input wire logic                 flush,
    input wire logic                 stall,
    input wire logic                 mem_wait,
    input wire logic                 c_accept,
    input wire cop_pkg::cop_issue_t  c_issue,
    input wire logic [`COP_XLEN-1:0] e_pc,
    input wire cop_pkg::cop_result_t e_result
);

    int fail_count = 0;

    // Cleared stages show nothing on the next cycle
    clear_kills_valid: assert property (@(posedge CLK)
        (rst || flush) |=> !e_result.valid && !c_accept)
        else begin
            fail_count++;
            $error("result valid or accept high in the cycle after reset or flush");
        end

    write_or_trap: assert property (@(posedge CLK) disable iff (rst)
        !(e_result.reg_w_en && e_result.exc_en))
        else begin
            fail_count++;
            $error("register write and exception raised together");
        end

    no_x0_write: assert property (@(posedge CLK) disable iff (rst)
        e_result.reg_w_en |-> (e_result.reg_w_rd != '0))
        else begin
            fail_count++;
            $error("register write enabled for x0");
        end

    // Frozen pipe keeps every output
    hold_keeps_outputs: assert property (@(posedge CLK)
        (!rst && !flush && (stall || mem_wait)) |=>
            $stable(e_result) && $stable(e_pc) && $stable(c_accept) && $stable(c_issue))
        else begin
            fail_count++;
            $error("outputs changed while the pipeline was held");
        end

endmodule

bind cop_top cop_asserts u_asserts (
    .CLK      (CLK),
    .rst      (rst),
    .flush    (flush),
    .stall    (stall),
    .mem_wait (mem_wait),
    .c_accept (c_accept),
    .c_issue  (c_issue),
    .e_pc     (e_pc),
    .e_result (e_result)
);

`default_nettype wire

//--- tb_cop_top.sv
`default_nettype none

`include "cop_defs.svh"

module tb_cop_top;

    localparam int MAX_LINES = 64;

    // One stim line with its expected values
    typedef struct packed {
        logic                 flush;
        logic                 stall;
        logic                 mem_wait;
        logic                 allow;
        cop_pkg::cop_issue_t  issue;
        logic [`COP_XLEN-1:0] rs1_data;
        logic [`COP_XLEN-1:0] rs2_data;
        logic                 accept;
        cop_pkg::cop_result_t result;
    } stim_row_t;

    logic                 CLK;
    logic                 rst;
    logic                 flush;
    logic                 stall;
    logic                 mem_wait;
    cop_pkg::cop_issue_t  issue;
    logic                 allow;
    logic [`COP_XLEN-1:0] rs1_data;
    logic [`COP_XLEN-1:0] rs2_data;
    logic                 c_accept;
    cop_pkg::cop_issue_t  c_issue;
    logic [`COP_XLEN-1:0] e_pc;
    cop_pkg::cop_result_t e_result;

    stim_row_t rows [MAX_LINES];
    int        n_lines;
    int        errors;
    int        cycle_count = 0;
    int        cycle_limit = 1000;
    // Stim line in each of check, ready and exec or -1 when empty
    int        m_line [3];
    logic      a_flush;
    logic      a_hold;
    int        a_line;

    cop_top i_cop_top (
        .CLK      (CLK),
        .rst      (rst),
        .flush    (flush),
        .stall    (stall),
        .mem_wait (mem_wait),
        .issue    (issue),
        .c_accept (c_accept),
        .c_issue  (c_issue),
        .allow    (allow),
        .rs1_data (rs1_data),
        .rs2_data (rs2_data),
        .e_pc     (e_pc),
        .e_result (e_result)
    );

    initial begin
        CLK = 1'b0;
        forever #2 CLK = ~CLK;
    end

    always @(posedge CLK) begin
        cycle_count = cycle_count + 1;
        if (cycle_count > cycle_limit) begin
            $display("Timeout: run did not finish within %0d cycles", cycle_limit);
            $display("*** TEST FAILED ***");
            $finish;
        end
    end

    task automatic check_value(input string name, input logic [127:0] got,
                               input logic [127:0] exp);
        if (got !== exp) begin
            errors++;
            $display("[FAIL] %s: got 0x%0h, expected 0x%0h at time %0t", name, got, exp, $time);
        end
    endtask

    task automatic read_stim();
        int          fd;
        int          cnt;
        string       text;
        logic [31:0] col [18];
        n_lines = 0;
        fd = $fopen("cop_stim.txt", "r");
        if (fd == 0) begin
            errors++;
            $display("Could not open cop_stim.txt for reading");
        end else begin
            while ($fgets(text, fd) != 0) begin
                if (text.getc(0) != "#") begin
                    cnt = $sscanf(text, "%h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h",
                                  col[0], col[1], col[2], col[3], col[4], col[5], col[6],
                                  col[7], col[8], col[9], col[10], col[11], col[12],
                                  col[13], col[14], col[15], col[16], col[17]);
                    if (cnt == 18 && n_lines < MAX_LINES) begin
                        // Valid follows accept gated by allow
                        rows[n_lines] = {col[0][0], col[1][0], col[2][0], col[3][0],
                            col[4], col[5][`COP_OPC_W-1:0], col[6][`COP_REG_W-1:0],
                            col[7][`COP_REG_W-1:0], col[8][`COP_REG_W-1:0], col[9],
                            col[10], col[11], col[12][0], col[12][0] & col[3][0],
                            col[13][0], col[14][`COP_REG_W-1:0], col[15], col[16][0],
                            col[17][`COP_EXC_W-1:0]};
                        n_lines++;
                    end else if (cnt > 0) begin
                        errors++;
                        $display("Stim line skipped, wrong column count or too many lines");
                    end
                end
            end
            $fclose(fd);
        end
        if (n_lines == 0) begin
            errors++;
            $display("No stimulus lines were read");
        end
    endtask

    function automatic stim_row_t row_at(int idx);
        stim_row_t row;
        row = '0;
        if (idx >= 0) begin
            row = rows[idx];
        end
        return row;
    endfunction

    task automatic drive_step(input int idx);
        stim_row_t row;
        stim_row_t nxt;
        row = row_at(idx);
        // Operands travel with the instruction about to enter exec
        nxt = row_at(m_line[1]);
        flush    <= row.flush;
        stall    <= row.stall;
        mem_wait <= row.mem_wait;
        issue    <= row.issue;
        allow    <= nxt.allow;
        rs1_data <= nxt.rs1_data;
        rs2_data <= nxt.rs2_data;
        a_flush = row.flush;
        a_hold  = row.stall || row.mem_wait;
        a_line  = idx;
    endtask

    task automatic step_model();
        if (a_flush) begin
            m_line = '{-1, -1, -1};
        end else if (!a_hold) begin
            m_line[2] = m_line[1];
            m_line[1] = m_line[0];
            m_line[0] = a_line;
        end
    endtask

    task automatic compare_outputs();
        stim_row_t chk;
        stim_row_t exe;
        chk = row_at(m_line[0]);
        exe = row_at(m_line[2]);
        check_value("c_accept", c_accept, chk.accept);
        check_value("c_issue", c_issue, chk.issue);
        check_value("e_pc", e_pc, exe.issue.pc);
        check_value("e_result.valid", e_result.valid, exe.result.valid);
        check_value("e_result.reg_w_en", e_result.reg_w_en, exe.result.reg_w_en);
        check_value("e_result.exc_en", e_result.exc_en, exe.result.exc_en);
        check_value("e_result.exc_code", e_result.exc_code, exe.result.exc_code);
        if (exe.result.reg_w_en) begin
            check_value("e_result.reg_w_rd", e_result.reg_w_rd, exe.result.reg_w_rd);
            check_value("e_result.reg_w_data", e_result.reg_w_data, exe.result.reg_w_data);
        end
    endtask

    initial begin
        errors = 0;
        rst      <= 1'b1;
        flush    <= 1'b0;
        stall    <= 1'b0;
        mem_wait <= 1'b0;
        issue    <= '0;
        allow    <= 1'b0;
        rs1_data <= '0;
        rs2_data <= '0;
        m_line = '{-1, -1, -1};
        read_stim();
        cycle_limit = 2 * n_lines + 20;
        repeat (2) @(posedge CLK);
        rst <= 1'b0;
        // A few idle steps at the end drain the pipe
        for (int k = 0; k < n_lines + 4; k++) begin
            drive_step(k < n_lines ? k : -1);
            @(negedge CLK);
            compare_outputs();
            @(posedge CLK);
            step_model();
        end
        $display("Summary: %0d check errors, %0d assertion failures",
                 errors, i_cop_top.u_asserts.fail_count);
        if (errors == 0 && i_cop_top.u_asserts.fail_count == 0) begin
            $display("*** TEST PASSED ***");
        end else begin
            $display("*** TEST FAILED ***");
        end
        $finish;
    end

endmodule

`default_nettype wire

//--- cop.f
+incdir+.
cop_pkg.sv
cop_decoder.sv
cop_alu.sv
cop_mini.sv
cop_top.sv
cop_asserts.sv
tb_cop_top.sv

//--- Bender.yml
package:
  name: cop

sources:
  - include_dirs:
      - .
    files:
      - cop_pkg.sv
      - cop_decoder.sv
      - cop_alu.sv
      - cop_mini.sv
      - cop_top.sv
  - target: test
    include_dirs:
      - .
    files:
      - cop_asserts.sv
      - tb_cop_top.sv

//--- cop_stim.txt
# fl st mw al pc opcode rd rs1 rs2 imm rs1_data rs2_data | acc wen rd data exc code (all hex)
# Operands and allow belong to the instruction on the same line
0 0 0 1 00000100 00033 01 02 03 00000000 7fffffff 00000001 1 1 01 80000000 0 0
0 0 0 1 00000104 08033 02 02 03 00000000 00000000 00000001 1 1 02 ffffffff 0 0
0 0 0 1 00000108 000b3 03 04 05 00000000 00000001 00000025 1 1 03 00000020 0 0
0 0 0 1 0000010c 00133 04 04 05 00000000 80000000 00000001 1 1 04 00000001 0 0
0 0 0 1 00000110 001b3 05 04 05 00000000 80000000 00000001 1 1 05 00000000 0 0
0 0 0 1 00000114 00233 06 06 07 00000000 f0f0f0f0 ff00ff00 1 1 06 0ff00ff0 0 0
0 0 0 1 00000118 002b3 07 06 07 00000000 80000000 0000003f 1 1 07 00000001 0 0
0 0 0 1 0000011c 082b3 08 08 09 00000000 80000000 00000024 1 1 08 f8000000 0 0
0 0 0 1 00000120 00333 09 08 09 00000000 12340000 00005678 1 1 09 12345678 0 0
0 0 0 1 00000124 003b3 0a 0a 0b 00000000 deadbeef 0000ffff 1 1 0a 0000beef 0 0
0 0 0 1 00000128 1fc13 0b 01 00 ffffffff 00000010 aaaaaaaa 1 1 0b 0000000f 0 0
0 0 0 1 0000012c 00113 0c 01 00 ffffffff fffffffe aaaaaaaa 1 1 0c 00000001 0 0
0 0 0 1 00000130 00193 0d 01 00 ffffffff fffffffe aaaaaaaa 1 1 0d 00000001 0 0
0 0 0 1 00000134 00213 0e 01 00 fffff800 0000ffff aaaaaaaa 1 1 0e ffff07ff 0 0
0 0 0 1 00000138 00313 0f 01 00 000000ff 00000100 aaaaaaaa 1 1 0f 000001ff 0 0
0 0 0 1 0000013c 00393 10 01 00 000007f0 ffffffff aaaaaaaa 1 1 10 000007f0 0 0
0 0 0 1 00000140 00093 11 01 00 0000001f 00000003 aaaaaaaa 1 1 11 80000000 0 0
0 0 0 1 00000144 00293 12 01 00 00000010 ffffffff aaaaaaaa 1 1 12 0000ffff 0 0
0 0 0 1 00000148 08293 13 01 00 00000404 80000010 aaaaaaaa 1 1 13 f8000001 0 0
0 0 0 1 0000014c 00103 01 02 00 00000004 00000000 00000000 0 0 00 00000000 0 0
0 0 0 1 00000150 00063 00 02 03 00000008 00000000 00000000 0 0 00 00000000 0 0
0 0 0 1 00000154 00433 01 02 03 00000000 00000003 00000005 0 0 00 00000000 0 0
0 0 0 1 00000158 00033 00 02 03 00000000 00000001 00000002 1 0 00 00000000 0 0
0 0 0 0 0000015c 00033 05 02 03 00000000 00000001 00000002 1 0 00 00000000 0 0
0 0 0 1 00000160 08093 03 01 00 00000403 00000001 00000000 1 0 00 00000000 1 2
0 0 0 0 00000164 00693 04 01 00 00000023 00000001 00000000 1 0 00 00000000 0 0
0 0 0 1 00000200 00013 01 02 00 00000001 00000001 00000000 1 1 01 00000002 0 0
0 1 0 1 00000204 00213 02 02 00 0000000f 000000ff 00000000 1 1 02 000000f0 0 0
0 0 0 1 00000204 00213 02 02 00 0000000f 000000ff 00000000 1 1 02 000000f0 0 0
0 0 1 1 00000208 00313 03 02 00 00000001 00000100 00000000 1 1 03 00000101 0 0
0 0 1 1 00000208 00313 03 02 00 00000001 00000100 00000000 1 1 03 00000101 0 0
0 0 0 1 00000208 00313 03 02 00 00000001 00000100 00000000 1 1 03 00000101 0 0
0 1 1 1 0000020c 08033 04 02 03 00000000 00000005 00000007 1 1 04 fffffffe 0 0
0 0 0 1 0000020c 08033 04 02 03 00000000 00000005 00000007 1 1 04 fffffffe 0 0
0 0 0 1 00000300 00033 05 02 03 00000000 00000001 00000001 1 1 05 00000002 0 0
0 0 0 1 00000304 000b3 06 02 03 00000000 00000001 00000004 1 1 06 00000010 0 0
1 1 0 1 00000308 003b3 07 02 03 00000000 0000ffff 000000ff 1 1 07 000000ff 0 0
0 0 0 1 0000030c 00333 08 02 03 00000000 0000000f 000000f0 1 1 08 000000ff 0 0
0 1 0 1 00000310 082b3 09 02 03 00000000 ffffff00 00000008 1 1 09 ffffffff 0 0
0 0 0 1 00000310 082b3 09 02 03 00000000 ffffff00 00000008 1 1 09 ffffffff 0 0
0 0 0 1 00000314 001b3 0a 02 03 00000000 00000000 00000001 1 1 0a 00000001 0 0
